// ==== src.f ====
source/nocPkg.sv
source/holdTimerBank.sv
source/rotatePriority.sv
source/switchArbiter.sv
source/routerOutputPort.sv
sim/switchArbiter_properties.sv
sim/routerOutputPort_tb.sv

// ==== sim/routerOutputPort_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module routerOutputPort_tb;

  localparam int randomCycles = 1500;
  localparam int maxCycles = 2000;  // reset, directed and random cycles with margin.

  logic                                                 clk;
  logic                                                 rst;
  logic [nocPkg::numPorts-1:0]                          req;
  logic [nocPkg::numPorts-1:0][nocPkg::flitIdWidth-1:0] flitId;
  logic [nocPkg::numPorts-1:0][nocPkg::lengthWidth-1:0] length;
  logic [nocPkg::numPorts-1:0][nocPkg::flitWidth-1:0]   flitIn;
  logic [nocPkg::numPorts-1:0]                          grant;
  logic [nocPkg::flitWidth-1:0]                         outFlit;
  logic                                                 outValid;

  logic [15:0] lfsr = 16'd43;
  int          cycleCount = 0;

  // reference model of the arbiter. Owner -1 means idle.
  int                             modelOwner = -1;
  logic                           modelLive = 1'b0;
  logic [nocPkg::lengthWidth-1:0] modelLimit [nocPkg::numPorts];
  logic [nocPkg::lengthWidth-1:0] modelCount [nocPkg::numPorts];

  routerOutputPort routerOutputPort_inst (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .flitId   (flitId),
    .length   (length),
    .flitIn   (flitIn),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // taps 16, 14, 13, 11.
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic takeBits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsrNext(lfsr);
      bits = {bits[30:0], lfsr[0]};
    end
  endtask

  // owner after one clock: keep the owner while it requests and has time left,
  // otherwise search the ports after it in rotating order, the owner last.
  function automatic int nextOwner(input int owner, input logic [nocPkg::numPorts-1:0] reqNow,
                                   input logic [nocPkg::numPorts-1:0] expired);
    int cand;
    if (owner >= 0 && reqNow[owner] && !expired[owner])
    begin
      return owner;
    end
    for (int i = 1; i <= nocPkg::numPorts; i++)
    begin
      cand = (owner < 0) ? i - 1 : (owner + i) % nocPkg::numPorts;
      if (reqNow[cand])
      begin
        return cand;
      end
    end
    return -1;
  endfunction

  task automatic randomFlits();
    logic [nocPkg::numPorts-1:0][nocPkg::flitWidth-1:0] words;
    logic [31:0] bits;
    for (int p = 0; p < nocPkg::numPorts; p++)
    begin
      takeBits(nocPkg::flitWidth, bits);
      words[p] = bits;
    end
    flitIn <= words;
  endtask

  // one directed cycle. Callers may override flitId after it returns.
  task automatic tick();
    logic [nocPkg::numPorts-1:0][nocPkg::flitIdWidth-1:0] ids;
    @(posedge clk);
    for (int p = 0; p < nocPkg::numPorts; p++)
    begin
      ids[p] = nocPkg::body;
    end
    flitId <= ids;
    randomFlits();
  endtask

  task automatic setHeader(input int port, input int len);
    logic [nocPkg::numPorts-1:0][nocPkg::flitIdWidth-1:0] ids;
    logic [nocPkg::numPorts-1:0][nocPkg::lengthWidth-1:0] lens;
    lens = length;
    for (int p = 0; p < nocPkg::numPorts; p++)
    begin
      ids[p] = nocPkg::body;
    end
    ids[port] = nocPkg::header;
    lens[port] = nocPkg::lengthWidth'(len);
    flitId <= ids;
    length <= lens;
  endtask

  task automatic randomCycle();
    logic [nocPkg::numPorts-1:0]                          nextReq;
    logic [nocPkg::numPorts-1:0][nocPkg::flitIdWidth-1:0] nextIds;
    logic [nocPkg::numPorts-1:0][nocPkg::lengthWidth-1:0] nextLens;
    logic [31:0]                                          bits;
    @(posedge clk);
    nextReq = req;
    nextLens = length;
    for (int p = 0; p < nocPkg::numPorts; p++)
    begin
      takeBits(3, bits);
      if (bits[2:0] == 3'd0)
      begin
        nextReq[p] = ~nextReq[p];  // a request flips about once in eight cycles.
      end
      takeBits(3, bits);
      if (bits[2:0] == 3'd0)
      begin
        nextIds[p] = nocPkg::header;
        takeBits(3, bits);
        nextLens[p] = nocPkg::lengthWidth'(bits[2:0]);  // short packets, so timeouts are common.
      end
      else
      begin
        nextIds[p] = nocPkg::body;
      end
    end
    req <= nextReq;
    flitId <= nextIds;
    length <= nextLens;
    randomFlits();
  endtask

  // model steps on the same edge as the DUT and sees the same pre-edge inputs.
  always @(posedge clk)
  begin : model
    logic [nocPkg::numPorts-1:0] expired;
    logic                        hold;
    if (rst)
    begin
      modelOwner = -1;
      for (int p = 0; p < nocPkg::numPorts; p++)
      begin
        modelLimit[p] = '0;
        modelCount[p] = '0;
      end
      modelLive = 1'b1;
    end
    else if (modelLive)
    begin
      for (int p = 0; p < nocPkg::numPorts; p++)
      begin
        expired[p] = (modelCount[p] == modelLimit[p]);
      end
      hold = (modelOwner >= 0) && req[modelOwner] && !expired[modelOwner];
      for (int p = 0; p < nocPkg::numPorts; p++)
      begin
        if (flitId[p] == nocPkg::header)
        begin
          modelLimit[p] = length[p];
        end
        modelCount[p] = (hold && p == modelOwner) ? modelCount[p] + 1'b1 : '0;
      end
      modelOwner = nextOwner(modelOwner, req, expired);
    end
  end

  // outputs are settled by the falling edge.
  always @(negedge clk)
  begin : compare
    logic [nocPkg::numPorts-1:0]  expGrant;
    logic                         expValid;
    logic [nocPkg::flitWidth-1:0] expFlit;
    if (modelLive)
    begin
      expGrant = '0;
      expValid = 1'b0;
      expFlit = '0;
      if (modelOwner >= 0)
      begin
        expGrant[modelOwner] = 1'b1;
        expValid = req[modelOwner];
        expFlit = flitIn[modelOwner];
      end
      assert (grant === expGrant)
      else
      begin
        $display("ERR %0t grant expected %b actual %b", $time, expGrant, grant);
        $display("Some tests failed");
        $fatal(1);
      end
      assert (outValid === expValid)
      else
      begin
        $display("ERR %0t outValid expected %b actual %b", $time, expValid, outValid);
        $display("Some tests failed");
        $fatal(1);
      end
      assert (outFlit === expFlit)
      else
      begin
        $display("ERR %0t outFlit expected %h actual %h", $time, expFlit, outFlit);
        $display("Some tests failed");
        $fatal(1);
      end
      assert (routerOutputPort_inst.switchArbiter_inst.properties_inst.failCount == 0)
      else
      begin
        $display("A bound assertion on the switch arbiter failed before %0t.", $time);
        $display("Some tests failed");
        $fatal(1);
      end
    end
  end

  always @(posedge clk)
  begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= maxCycles)
    begin
      $display("The run timed out after %0d cycles without finishing.", cycleCount);
      $display("Some tests failed");
      $fatal(1);
    end
  end

  initial
  begin
    rst = 1'b1;
    req = '0;
    flitId = '0;
    length = '0;
    flitIn = '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    repeat (4) tick();  // no requests, so grant must stay zero.

    // headers on every port. Lengths by port are 2, 0, 3, 1, 4.
    tick();
    flitId <= {nocPkg::numPorts{3'd1}};
    length <= {12'd4, 12'd1, 12'd3, 12'd0, 12'd2};

    tick();
    req <= '1;  // all ports at once, Local wins first.
    repeat (40) tick();

    // a long packet on East that is released early.
    tick();
    req <= '0;
    setHeader(2, 9);
    tick();
    req <= 5'b00100;
    repeat (3) tick();
    tick();
    req <= 5'b01100;
    repeat (2) tick();
    tick();
    req <= 5'b01000;  // East drops, West takes over.
    repeat (8) tick();  // West alone is regranted after each timeout.
    tick();
    req <= '0;
    repeat (3) tick();

    repeat (randomCycles) randomCycle();

    @(posedge clk);
    req <= '0;
    repeat (3) @(posedge clk);
    if (routerOutputPort_inst.switchArbiter_inst.properties_inst.failCount == 0)
    begin
      $display("All tests passed");
      $finish;
    end
    else
    begin
      $display("Some tests failed");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// ==== sim/switchArbiter_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module switchArbiter_properties (
  input logic                        clk,
  input logic                        rst,
  input logic [nocPkg::numPorts-1:0] grant,
  input logic [nocPkg::numPorts-1:0] runTimer,
  input logic                        outValid
);

  int failCount = 0;  // assertion failures so far.

  // at most one port owns the output.
  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
  else
  begin
    $error("grant is not one-hot or zero: %b", grant);
    failCount = failCount + 1;
  end

  validNeedsGrant: assert property (@(posedge clk) disable iff (rst) outValid |-> (grant != '0))
  else
  begin
    $error("outValid is high while no port is granted");
    failCount = failCount + 1;
  end

  // only the owner's timer may run.
  timerOnlyOwner: assert property (@(posedge clk) disable iff (rst)
    $onehot0(runTimer) && ((runTimer & ~grant) == '0))
  else
  begin
    $error("runTimer %b does not match grant %b", runTimer, grant);
    failCount = failCount + 1;
  end

endmodule

bind switchArbiter switchArbiter_properties properties_inst (
  .clk      (clk),
  .rst      (rst),
  .grant    (grant),
  .runTimer (runTimer),
  .outValid (outValid)
);

`default_nettype wire

// ==== source/routerOutputPort.sv ====
`timescale 1ns/1ps
`default_nettype none

module routerOutputPort (
  input  logic                                                 clk,
  input  logic                                                 rst,
  input  logic [nocPkg::numPorts-1:0]                          req,
  input  logic [nocPkg::numPorts-1:0][nocPkg::flitIdWidth-1:0] flitId,
  input  logic [nocPkg::numPorts-1:0][nocPkg::lengthWidth-1:0] length,
  input  logic [nocPkg::numPorts-1:0][nocPkg::flitWidth-1:0]   flitIn,
  output logic [nocPkg::numPorts-1:0]                          grant,
  output logic [nocPkg::flitWidth-1:0]                         outFlit,
  output logic                                                 outValid
);

  logic [nocPkg::numPorts-1:0] timesUp;
  logic [nocPkg::numPorts-1:0] runTimer;
  nocPkg::arbState             nextPort;
  nocPkg::arbState             state;

  // per-port hold limits and counters.
  holdTimerBank holdTimerBank_inst (
    .clk      (clk),
    .rst      (rst),
    .flitId   (flitId),
    .length   (length),
    .runTimer (runTimer),
    .timesUp  (timesUp)
  );

  // next port to serve, searched in rotating order after the current owner.
  rotatePriority rotatePriority_inst (
    .req      (req),
    .state    (state),
    .nextPort (nextPort)
  );

  // grant FSM and flit mux.
  switchArbiter switchArbiter_inst (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .timesUp  (timesUp),
    .nextPort (nextPort),
    .flitIn   (flitIn),
    .state    (state),
    .runTimer (runTimer),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

endmodule

`default_nettype wire

// ==== source/switchArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module switchArbiter (
  input  logic                                             clk,
  input  logic                                             rst,
  input  logic [nocPkg::numPorts-1:0]                        req,
  input  logic [nocPkg::numPorts-1:0]                        timesUp,
  input  nocPkg::arbState                                    nextPort,
  input  logic [nocPkg::numPorts-1:0][nocPkg::flitWidth-1:0] flitIn,
  output nocPkg::arbState                                    state,
  output logic [nocPkg::numPorts-1:0]                        runTimer,
  output logic [nocPkg::numPorts-1:0]                        grant,
  output logic [nocPkg::flitWidth-1:0]                       outFlit,
  output logic                                               outValid
);

  nocPkg::arbState stateNext;
  logic            hold;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= nocPkg::idle;
    end
    else
    begin
      state <= stateNext;
    end
  end

  // one-hot decode of the registered state. Idle and unused codes grant nobody.
  always_comb
  begin
    grant = '0;
    for (int p = 0; p < nocPkg::numPorts; p++)
    begin
      if (state == nocPkg::arbState'(p + 1))
      begin
        grant[p] = 1'b1;
      end
    end
  end

  // the owner keeps the output while it requests and its timer has not run out.
  // Because grant is one-hot this only looks at the owner's bits.
  assign hold = |(grant & req & ~timesUp);

  always_comb
  begin
    if (hold)
    begin
      stateNext = state;
      runTimer = grant;  // count only the cycles the owner actually keeps.
    end
    else
    begin
      stateNext = nextPort;  // from idle, after a timeout, or after a release.
      runTimer = '0;
    end
  end

  // output flit mux.
  always_comb
  begin
    outFlit = '0;
    outValid = 1'b0;
    for (int p = 0; p < nocPkg::numPorts; p++)
    begin
      if (grant[p])
      begin
        outFlit = flitIn[p];
        outValid = req[p];  // a granted port that drops req sends nothing.
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/rotatePriority.sv ====
`timescale 1ns/1ps
`default_nettype none

module rotatePriority (
  input  logic [nocPkg::numPorts-1:0] req,
  input  nocPkg::arbState             state,
  output nocPkg::arbState             nextPort
);

  logic [nocPkg::portIdxWidth-1:0]   ownerCode;
  logic [nocPkg::portIdxWidth-1:0]   start;
  logic [2*nocPkg::numPorts-1:0]     doubled;
  logic [nocPkg::numPorts-1:0]       rotated;
  logic [nocPkg::portIdxWidth-1:0]   offset;
  logic                              found;
  logic [nocPkg::portIdxWidth:0]     portSum;

  always_comb
  begin
    // the state code of owner p is p+1, which is where its search begins.
    // idle, South and unused codes start from Local.
    ownerCode = state;
    if (ownerCode >= nocPkg::numPorts)
    begin
      start = '0;
    end
    else
    begin
      start = ownerCode;
    end

    doubled = {req, req};
    rotated = doubled[start +: nocPkg::numPorts];  // bit 0 is now the first port to try.

    found = 1'b0;
    offset = '0;
    for (int i = nocPkg::numPorts - 1; i >= 0; i--)
    begin
      if (rotated[i])
      begin
        found = 1'b1;
        offset = nocPkg::portIdxWidth'(i);
      end
    end

    // undo the rotation to get back the real port index.
    portSum = {1'b0, start} + {1'b0, offset};
    if (portSum >= nocPkg::numPorts)
    begin
      portSum = portSum - (nocPkg::portIdxWidth + 1)'(nocPkg::numPorts);
    end

    if (found)
    begin
      nextPort = nocPkg::arbState'(portSum[nocPkg::portIdxWidth-1:0] + 1'b1);
    end
    else
    begin
      nextPort = nocPkg::idle;
    end
  end

endmodule

`default_nettype wire

// ==== source/holdTimerBank.sv ====
`timescale 1ns/1ps
`default_nettype none

module holdTimerBank (
  input  logic                                               clk,
  input  logic                                               rst,
  input  logic [nocPkg::numPorts-1:0][nocPkg::flitIdWidth-1:0] flitId,
  input  logic [nocPkg::numPorts-1:0][nocPkg::lengthWidth-1:0] length,
  input  logic [nocPkg::numPorts-1:0]                          runTimer,
  output logic [nocPkg::numPorts-1:0]                          timesUp
);

  for (genvar p = 0; p < nocPkg::numPorts; p++)
  begin : gTimer
    logic [nocPkg::lengthWidth-1:0] limit;
    logic [nocPkg::lengthWidth-1:0] count;

    always_ff @(posedge clk)
    begin
      if (rst)
      begin
        limit <= '0;
        count <= '0;
      end
      else
      begin
        // a header loads the limit even while another port owns the output.
        if (flitId[p] == nocPkg::header)
        begin
          limit <= length[p];
        end

        if (runTimer[p])
        begin
          count <= count + 1'b1;
        end
        else
        begin
          count <= '0;  // any cycle without a hold restarts the count.
        end
      end
    end

    // expiry is high in the cycle the count reaches the limit.
    assign timesUp[p] = (count == limit);
  end

endmodule

`default_nettype wire

// ==== source/nocPkg.sv ====
`default_nettype none

package nocPkg;

  // router geometry. Port order is Local 0, North 1, East 2, West 3, South 4.
  localparam int numPorts = 5;
  localparam int portIdxWidth = $clog2(numPorts);

  // flit fields.
  localparam int flitWidth = 32;
  localparam int flitIdWidth = 3;
  localparam int lengthWidth = 12;  // packet length and hold counter.

  localparam int stateWidth = 3;

  // each grant state carries its port index plus one, so idle sits at zero.
  // rotatePriority and switchArbiter both rely on this.
  typedef enum logic [stateWidth-1:0] {
    idle       = 3'd0,
    grantLocal = 3'd1,
    grantNorth = 3'd2,
    grantEast  = 3'd3,
    grantWest  = 3'd4,
    grantSouth = 3'd5
  } arbState;

  // flit type codes on flitId.
  typedef enum logic [flitIdWidth-1:0] {
    none   = 3'd0,
    header = 3'd1,  // only a header reloads the hold limit.
    body   = 3'd2,
    tail   = 3'd3
  } flitKind;

endpackage

`default_nettype wire
